/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = executeStage_tb
FILELIST  = executeStage.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* executeStage.f */
+incdir+verilog
verilog/isaPkg.sv
verilog/aluPkg.sv
verilog/aluDecode.sv
verilog/addLogicUnit.sv
verilog/shiftUnit.sv
verilog/resultSelect.sv
verilog/executeStage.sv
test/executeStage_assertions.sv
test/executeStage_tb.sv

/* test/alu_cases.txt */
subi_pos 01000 00 0003 0000 0000 05 0002 0
subi_neg 01000 00 0004 0000 0000 1e fffa 0
addi_neg 01001 00 0010 0000 0000 1f 000f 0
addi_hi_bits 01001 00 1234 0000 0000 ea 123e 0
andni 01010 00 00ff 0000 0000 0f 00f0 0
xori 01011 00 a5a5 0000 0000 1f a5ba 0
add_reg 11011 00 1234 4321 0000 00 5555 0
sub_reg 11011 01 0005 0003 0000 00 fffe 0
xor_reg 11011 10 ff00 0ff0 0000 00 f0f0 0
andn_reg 11011 11 ff0f 0f0f 0000 00 f000 0
seq_true 11100 00 1234 1234 0000 00 0001 0
seq_false 11100 00 1234 1235 0000 00 0000 0
slt_true 11101 00 0002 0005 0000 00 0001 0
slt_false 11101 00 0005 0002 0000 00 0000 0
sle_equal 11110 00 0007 0007 0000 00 0001 0
sle_greater 11110 00 0008 0007 0000 00 0000 0
sco_carry 11111 00 ffff 0001 0000 00 0001 0
sco_none 11111 00 7fff 0001 0000 00 0000 0
roli_0 10100 00 1234 0000 0000 00 1234 0
roli_1 10100 00 8001 0000 0000 01 0003 0
slli_1 10101 00 c001 0000 0000 01 8002 0
slli_15 10101 00 0003 0000 0000 0f 8000 0
rori_1 10110 00 0003 0000 0000 01 8001 0
rori_15 10110 00 8001 0000 0000 0f 0003 0
srli_0 10111 00 8421 0000 0000 f0 8421 0
srli_15 10111 00 8000 0000 0000 0f 0001 0
rol_reg 11010 00 1234 fff4 0000 00 2341 0
srl_reg 11010 11 8000 0013 0000 00 1000 0
btr 11001 00 1234 0000 0000 00 2c48 0
lbi_neg 11000 00 0000 0000 0000 80 ff80 0
lbi_pos 11000 00 0000 0000 0000 7f 007f 0
slbi 10010 00 12ab 0000 0000 cd abcd 0
ld_addr 10001 00 1000 0000 0000 1c 0ffc 0
jal_link 00110 00 5555 0000 0042 00 0042 0
beqz_zero 01100 00 0000 0000 0000 00 0000 1
beqz_pos 01100 00 0005 0000 0000 00 0005 0
bnez_neg 01101 00 8000 0000 0000 00 8000 1
bnez_zero 01101 00 0000 0000 0000 00 0000 0
bltz_neg 01110 00 ffff 0000 0000 00 ffff 1
bltz_pos 01110 00 0001 0000 0000 00 0001 0
bgez_zero 01111 00 0000 0000 0000 00 0000 1
bgez_neg 01111 00 8001 0000 0000 00 8001 0

/* test/executeStage_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module executeStage_assertions
    import isaPkg::*;
    import aluPkg::*;
(
    input logic         clk,
    input logic         rstN,
    input logic         inValid,
    input instrFields_t fields,
    input stageOut_t    out,
    input logic         outValid
);

    int         errorCount = 0;
    logic [4:0] opBits;
    logic       nonBranchIssue;

    assign opBits = fields.opcode;
    // 011xx is the branch group
    assign nonBranchIssue = inValid && (opBits[4:2] != 3'b011);

    resetQuiet: assert property (@(posedge clk) !rstN |-> !outValid)
        else begin
            errorCount++;
            $error("outValid high while rstN is low");
        end

    validFollows: assert property (@(posedge clk) disable iff (!rstN) inValid |=> outValid)
        else begin
            errorCount++;
            $error("outValid missing one cycle after inValid");
        end

    idleFollows: assert property (@(posedge clk) disable iff (!rstN) !inValid |=> !outValid)
        else begin
            errorCount++;
            $error("outValid high one cycle after inValid was low");
        end

    // branchTaken lags the opcode by the output register
    quietBranch: assert property (@(posedge clk) disable iff (!rstN)
                                  nonBranchIssue |=> !out.branchTaken)
        else begin
            errorCount++;
            $error("branchTaken high for a non-branch opcode");
        end

endmodule

bind executeStage executeStage_assertions checks_i (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .fields   (fields),
    .out      (out),
    .outValid (outValid)
);

`default_nettype wire

/* test/executeStage_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module executeStage_tb
    import isaPkg::*;
    import aluPkg::*;
();

    localparam int clkPeriod   = 20;
    localparam int randomCount = 50;
    localparam int maxCases    = 64;
    localparam string caseFile = "test/alu_cases.txt";

    logic         clk;
    logic         rstN;
    logic         inValid;
    instrFields_t fields;
    stageOut_t    out;
    logic         outValid;

    string        caseName [maxCases];
    instrFields_t caseFields [maxCases];
    dataWord_t    caseWord [maxCases];
    logic         caseTaken [maxCases];
    int           caseCount;
    bit           casesLoaded;

    // step issued one cycle earlier and waiting for its check
    string        pendName;
    bit           pendIssued;
    bit           pendIdle;
    dataWord_t    pendWord;
    logic         pendTaken;
    dataWord_t    heldWord;

    int           passCount;
    int           failCount;
    bit           testFailed;

    executeStage dut_i (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .fields   (fields),
        .out      (out),
        .outValid (outValid)
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    task automatic checkWord(input string name, input dataWord_t expected,
                             input dataWord_t actual);
        if (actual !== expected) begin
            $display("** Error %s: result expected %h, actual %h", name, expected, actual);
            testFailed = 1'b1;
        end
    endtask

    task automatic checkTaken(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error %s: branchTaken expected %b, actual %b", name, expected, actual);
            testFailed = 1'b1;
        end
    endtask

    task automatic finishTest(input string name);
        if (testFailed) begin
            failCount++;
            $display("FAIL %s", name);
        end else begin
            passCount++;
            $display("ok   %s", name);
        end
        testFailed = 1'b0;
    endtask

    task automatic checkPending();
        if (pendIssued) begin
            if (pendIdle) begin
                if (outValid !== 1'b0) begin
                    $display("%s: outValid was high one cycle after an idle input", pendName);
                    testFailed = 1'b1;
                end
                // idle cycles keep the last result
                checkWord(pendName, heldWord, out.result);
            end else if (outValid !== 1'b1) begin
                $display("%s: outValid did not rise one cycle after the issue", pendName);
                testFailed = 1'b1;
            end else begin
                checkWord(pendName, pendWord, out.result);
                checkTaken(pendName, pendTaken, out.branchTaken);
            end
            if (!pendIdle) begin
                heldWord = pendWord;
            end
            finishTest(pendName);
        end
        pendIssued = 1'b0;
    endtask

    // drive on the rising edge, check the previous step at the falling edge
    task automatic step(input string name, input bit valid, input instrFields_t f,
                        input dataWord_t expWord, input logic expTaken);
        @(posedge clk);
        inValid <= valid;
        fields  <= f;
        @(negedge clk);
        checkPending();
        pendName   = name;
        pendIdle   = !valid;
        pendWord   = expWord;
        pendTaken  = expTaken;
        pendIssued = 1'b1;
    endtask

    task automatic loadCases();
        int               fd;
        int               n;
        logic [8*24-1:0]  nameBuf;
        logic [4:0]       opBits;
        logic [1:0]       fnBits;
        dataWord_t        rs;
        dataWord_t        rt;
        dataWord_t        pc;
        dataWord_t        word;
        logic [7:0]       imm;
        logic             taken;
        instrFields_t     f;
        caseCount = 0;
        fd = $fopen(caseFile, "r");
        if (fd == 0) begin
            $display("Cannot open the case file %s", caseFile);
        end else begin
            do begin
                n = $fscanf(fd, "%s %b %b %h %h %h %h %h %b", nameBuf, opBits, fnBits,
                            rs, rt, pc, imm, word, taken);
                if (n == 9) begin
                    f.opcode = opcode_e'(opBits);
                    f.funct  = funct_e'(fnBits);
                    f.rs     = rs;
                    f.rt     = rt;
                    f.pc     = pc;
                    f.imm    = imm;
                    caseName[caseCount]   = $sformatf("%0s", nameBuf);
                    caseFields[caseCount] = f;
                    caseWord[caseCount]   = word;
                    caseTaken[caseCount]  = taken;
                    caseCount++;
                end
            end while (n == 9 && caseCount < maxCases);
            $fclose(fd);
        end
    endtask

    initial begin
        wait (casesLoaded);
        #((caseCount + randomCount + 10) * clkPeriod * 4);
        $display("Watchdog expired before all tests finished");
        $display("Regression failed");
        $finish;
    end

    initial begin
        logic [31:0]  rnd;
        instrFields_t f;
        dataWord_t    expWord;
        bit           isSub;
        int           assertErrors;
        rstN       = 1'b0;
        inValid    = 1'b0;
        fields     = '0;
        pendIssued = 1'b0;
        pendIdle   = 1'b0;
        heldWord   = '0;
        passCount  = 0;
        failCount  = 0;
        testFailed = 1'b0;
        void'($urandom(53));
        loadCases();
        if (caseCount == 0) begin
            $display("The case file holds no readable cases");
            testFailed = 1'b1;
            finishTest("load_cases");
        end
        casesLoaded = 1'b1;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;

        // nothing issued yet, so outValid stays low and the result is zero
        step("idle_after_reset_0", 1'b0, '0, '0, 1'b0);
        step("idle_after_reset_1", 1'b0, '0, '0, 1'b0);

        for (int i = 0; i < caseCount; i++) begin
            step(caseName[i], 1'b1, caseFields[i], caseWord[i], caseTaken[i]);
            if (i % 10 == 4) begin
                step($sformatf("gap_after_%s", caseName[i]), 1'b0, '0, '0, 1'b0);
            end
        end

        // register add and subtract with subtract as rt minus rs
        for (int i = 0; i < randomCount; i++) begin
            f        = '0;
            f.opcode = opArithReg;
            rnd      = $urandom;
            f.rs     = rnd[15:0];
            rnd      = $urandom;
            f.rt     = rnd[15:0];
            isSub    = rnd[16];
            f.funct  = isSub ? fnSub : fnAdd;
            if (isSub) begin
                expWord = f.rt - f.rs;
            end else begin
                expWord = f.rs + f.rt;
            end
            step($sformatf("rand_%s_%0d", isSub ? "sub" : "add", i), 1'b1, f, expWord, 1'b0);
        end

        step("final_gap", 1'b0, '0, '0, 1'b0);
        @(negedge clk);
        checkPending();

        assertErrors = dut_i.checks_i.errorCount;
        $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
                 passCount, failCount, assertErrors);
        if (failCount == 0 && assertErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/addLogicUnit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "alu_config.svh"

module addLogicUnit
    import isaPkg::*;
    import aluPkg::*;
(
    input  instrFields_t fields,
    input  aluCtrl_t     ctrl,
    output arithResult_t arith
);

    dataWord_t             immSext;
    dataWord_t             immZext;
    dataWord_t             srcB;
    dataWord_t             opA;
    dataWord_t             opB;
    dataWord_t             sum;
    logic                  carryIn;
    logic [`DATA_WIDTH:0]  carry;

    always_comb begin
        immSext = {{(`DATA_WIDTH-`SHORT_IMM_WIDTH){fields.imm[`SHORT_IMM_WIDTH-1]}},
                   fields.imm[`SHORT_IMM_WIDTH-1:0]};
        immZext = {{(`DATA_WIDTH-`SHORT_IMM_WIDTH){1'b0}}, fields.imm[`SHORT_IMM_WIDTH-1:0]};
    end

    always_comb begin
        case (ctrl.srcSel)
            sext5:    srcB = immSext;
            zext5:    srcB = immZext;
            zeroWord: srcB = '0;
            default:  srcB = fields.rt;
        endcase
    end

    // two's complement negate is invert plus carry in
    always_comb begin
        opA     = ctrl.invA ? ~fields.rs : fields.rs;
        opB     = ctrl.invB ? ~srcB : srcB;
        carryIn = ctrl.invA | ctrl.invB;
    end

    // ripple carry chain
    always_comb begin
        carry[0] = carryIn;
        for (int i = 0; i < `DATA_WIDTH; i++) begin
            sum[i]     = opA[i] ^ opB[i] ^ carry[i];
            carry[i+1] = (opA[i] & opB[i]) | (carry[i] & (opA[i] ^ opB[i]));
        end
    end

    always_comb begin
        case (ctrl.arithOp)
            aluXor:    arith.word = opA ^ opB;
            aluAndNot: arith.word = opA & ~opB;
            default:   arith.word = sum;
        endcase
        arith.zero  = ~|sum;
        // no overflow correction on lt
        arith.lt    = sum[`DATA_WIDTH-1];
        arith.carry = carry[`DATA_WIDTH];
    end

endmodule

`default_nettype wire

/* verilog/aluDecode.sv */
`timescale 1ns/100ps
`default_nettype none

module aluDecode
    import isaPkg::*;
    import aluPkg::*;
(
    input  opcode_e  opcode,
    input  funct_e   funct,
    output aluCtrl_t ctrl
);

    always_comb begin
        ctrl.invA        = 1'b0;
        ctrl.invB        = 1'b0;
        ctrl.srcSel      = rtWord;
        ctrl.arithOp     = aluAdd;
        ctrl.shiftOp     = rotLeft;
        ctrl.shiftFromRt = 1'b0;
        ctrl.resultSel   = selPc;
        ctrl.condSel     = condNone;

        case (opcode)
            opHalt, opNop, opSiic, opRti, opJ, opJr, opJal, opJalr: begin
                ctrl.resultSel = selPc;
            end
            // imm minus rs
            opSubi: begin
                ctrl.invA      = 1'b1;
                ctrl.srcSel    = sext5;
                ctrl.resultSel = selArith;
            end
            opAddi, opSt, opLd, opStu: begin
                ctrl.srcSel    = sext5;
                ctrl.resultSel = selArith;
            end
            opAndni: begin
                ctrl.srcSel    = zext5;
                ctrl.arithOp   = aluAndNot;
                ctrl.resultSel = selArith;
            end
            opXori: begin
                ctrl.srcSel    = zext5;
                ctrl.arithOp   = aluXor;
                ctrl.resultSel = selArith;
            end
            // adder passes rs through, flags come from the sum
            opBeqz, opBnez, opBltz, opBgez: begin
                ctrl.srcSel    = zeroWord;
                ctrl.resultSel = selArith;
                case (opcode)
                    opBeqz:  ctrl.condSel = condEqz;
                    opBnez:  ctrl.condSel = condNez;
                    opBltz:  ctrl.condSel = condLtz;
                    default: ctrl.condSel = condGez;
                endcase
            end
            opSlbi: ctrl.resultSel = selSlbi;
            opRoli: begin
                ctrl.shiftOp   = rotLeft;
                ctrl.resultSel = selShift;
            end
            opSlli: begin
                ctrl.shiftOp   = shiftLeft;
                ctrl.resultSel = selShift;
            end
            opRori: begin
                ctrl.shiftOp   = rotRight;
                ctrl.resultSel = selShift;
            end
            opSrli: begin
                ctrl.shiftOp   = shiftRight;
                ctrl.resultSel = selShift;
            end
            opLbi: ctrl.resultSel = selLoadImm;
            opBtr: ctrl.resultSel = selReverse;
            opShiftReg: begin
                ctrl.shiftOp     = shiftOp_e'(funct);
                ctrl.shiftFromRt = 1'b1;
                ctrl.resultSel   = selShift;
            end
            opArithReg: begin
                ctrl.resultSel = selArith;
                case (funct)
                    fnSub:    ctrl.invA    = 1'b1;
                    fnXor:    ctrl.arithOp = aluXor;
                    fnAndNot: ctrl.arithOp = aluAndNot;
                    default:  ctrl.arithOp = aluAdd;
                endcase
            end
            // compares work on rs minus rt
            opSeq, opSlt, opSle: begin
                ctrl.invB      = 1'b1;
                ctrl.resultSel = selSet;
                case (opcode)
                    opSeq:   ctrl.condSel = condSeq;
                    opSlt:   ctrl.condSel = condSlt;
                    default: ctrl.condSel = condSle;
                endcase
            end
            opSco: begin
                ctrl.resultSel = selSet;
                ctrl.condSel   = condSco;
            end
            default: ctrl.resultSel = selPc;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/aluPkg.sv */
`default_nettype none

package aluPkg;

    import isaPkg::*;

    typedef enum logic [1:0] {
        rtWord,
        sext5,
        zext5,
        zeroWord
    } srcSel_e;

    typedef enum logic [1:0] {
        aluAdd,
        aluXor,
        aluAndNot
    } arithOp_e;

    // bit 1 selects the right forms, bit 0 a logical shift
    typedef enum logic [1:0] {
        rotLeft    = 2'b00,
        shiftLeft  = 2'b01,
        rotRight   = 2'b10,
        shiftRight = 2'b11
    } shiftOp_e;

    typedef enum logic [2:0] {
        selPc,
        selArith,
        selShift,
        selSet,
        selLoadImm,
        selSlbi,
        selReverse
    } resultSel_e;

    typedef enum logic [3:0] {
        condNone,
        condEqz,
        condNez,
        condLtz,
        condGez,
        condSeq,
        condSlt,
        condSle,
        condSco
    } condSel_e;

    typedef struct packed {
        logic       invA;
        logic       invB;
        srcSel_e    srcSel;
        arithOp_e   arithOp;
        shiftOp_e   shiftOp;
        logic       shiftFromRt;
        resultSel_e resultSel;
        condSel_e   condSel;
    } aluCtrl_t;

    typedef struct packed {
        dataWord_t word;
        logic      zero;
        logic      lt;
        logic      carry;
    } arithResult_t;

    typedef struct packed {
        dataWord_t shifted;
        dataWord_t reversed;
        dataWord_t lbi;
        dataWord_t slbi;
    } shiftResult_t;

    typedef struct packed {
        dataWord_t result;
        logic      branchTaken;
    } stageOut_t;

endpackage

`default_nettype wire

/* verilog/alu_config.svh */
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// datapath width of the execute stage
`define DATA_WIDTH 16

// full immediate field, used by lbi and slbi
`define IMM_WIDTH 8

// short immediate used by the arithmetic and address forms
`define SHORT_IMM_WIDTH 5

// shift count taken from imm or rt
`define SHAMT_WIDTH 4

`endif

/* verilog/executeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module executeStage
    import isaPkg::*;
    import aluPkg::*;
(
    input  logic         clk,
    input  logic         rstN,
    input  logic         inValid,
    input  instrFields_t fields,
    output stageOut_t    out,
    output logic         outValid
);

    aluCtrl_t     ctrl;
    arithResult_t arith;
    shiftResult_t shiftRes;

    aluDecode decode_i (
        .opcode (fields.opcode),
        .funct  (fields.funct),
        .ctrl   (ctrl)
    );

    addLogicUnit addLogic_i (
        .fields (fields),
        .ctrl   (ctrl),
        .arith  (arith)
    );

    shiftUnit shifter_i (
        .fields (fields),
        .ctrl   (ctrl),
        .shift  (shiftRes)
    );

    // output register gives the one cycle latency
    resultSelect select_i (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .ctrl     (ctrl),
        .pc       (fields.pc),
        .arith    (arith),
        .shift    (shiftRes),
        .out      (out),
        .outValid (outValid)
    );

endmodule

`default_nettype wire

/* verilog/isaPkg.sv */
`default_nettype none

`include "alu_config.svh"

package isaPkg;

    typedef logic [`DATA_WIDTH-1:0] dataWord_t;

    typedef enum logic [4:0] {
        // link group returns pc
        opHalt     = 5'b00000,
        opNop      = 5'b00001,
        opSiic     = 5'b00010,
        opRti      = 5'b00011,
        opJ        = 5'b00100,
        opJr       = 5'b00101,
        opJal      = 5'b00110,
        opJalr     = 5'b00111,
        opSubi     = 5'b01000,
        opAddi     = 5'b01001,
        opAndni    = 5'b01010,
        opXori     = 5'b01011,
        opBeqz     = 5'b01100,
        opBnez     = 5'b01101,
        opBltz     = 5'b01110,
        opBgez     = 5'b01111,
        // address forms
        opSt       = 5'b10000,
        opLd       = 5'b10001,
        opSlbi     = 5'b10010,
        opStu      = 5'b10011,
        opRoli     = 5'b10100,
        opSlli     = 5'b10101,
        opRori     = 5'b10110,
        opSrli     = 5'b10111,
        opLbi      = 5'b11000,
        opBtr      = 5'b11001,
        opShiftReg = 5'b11010,
        opArithReg = 5'b11011,
        opSeq      = 5'b11100,
        opSlt      = 5'b11101,
        opSle      = 5'b11110,
        opSco      = 5'b11111
    } opcode_e;

    // meaning for opArithReg; opShiftReg reuses the bits as shift kind
    typedef enum logic [1:0] {
        fnAdd    = 2'b00,
        fnSub    = 2'b01,
        fnXor    = 2'b10,
        fnAndNot = 2'b11
    } funct_e;

    typedef struct packed {
        opcode_e                 opcode;
        funct_e                  funct;
        dataWord_t               rs;
        dataWord_t               rt;
        dataWord_t               pc;
        logic [`IMM_WIDTH-1:0]   imm;
    } instrFields_t;

endpackage

`default_nettype wire

/* verilog/resultSelect.sv */
`timescale 1ns/100ps
`default_nettype none

module resultSelect
    import isaPkg::*;
    import aluPkg::*;
(
    input  logic         clk,
    input  logic         rstN,
    input  logic         inValid,
    input  aluCtrl_t     ctrl,
    input  dataWord_t    pc,
    input  arithResult_t arith,
    input  shiftResult_t shift,
    output stageOut_t    out,
    output logic         outValid
);

    dataWord_t nextWord;
    logic      setBit;
    logic      takenNext;

    always_comb begin
        case (ctrl.condSel)
            condSeq: setBit = arith.zero;
            condSlt: setBit = arith.lt;
            condSle: setBit = arith.lt | arith.zero;
            condSco: setBit = arith.carry;
            default: setBit = 1'b0;
        endcase

        // branch flags see rs through the adder
        case (ctrl.condSel)
            condEqz: takenNext = arith.zero;
            condNez: takenNext = ~arith.zero;
            condLtz: takenNext = arith.lt;
            condGez: takenNext = ~arith.lt;
            default: takenNext = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl.resultSel)
            selPc:      nextWord = pc;
            selArith:   nextWord = arith.word;
            selShift:   nextWord = shift.shifted;
            selSet:     nextWord = dataWord_t'(setBit);
            selLoadImm: nextWord = shift.lbi;
            selSlbi:    nextWord = shift.slbi;
            selReverse: nextWord = shift.reversed;
            default:    nextWord = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            out      <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
            // hold last result while idle
            if (inValid) begin
                out.result      <= nextWord;
                out.branchTaken <= takenNext;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/shiftUnit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "alu_config.svh"

module shiftUnit
    import isaPkg::*;
    import aluPkg::*;
(
    input  instrFields_t fields,
    input  aluCtrl_t     ctrl,
    output shiftResult_t shift
);

    logic [`SHAMT_WIDTH-1:0] amount;
    logic                    isRight;
    logic                    isRotate;
    dataWord_t               rsReversed;
    dataWord_t               barrelIn;
    dataWord_t               barrelOut;

    function automatic dataWord_t reverseBits(input dataWord_t w);
        dataWord_t r;
        for (int i = 0; i < `DATA_WIDTH; i++) begin
            r[i] = w[`DATA_WIDTH-1-i];
        end
        return r;
    endfunction

    always_comb begin
        amount     = ctrl.shiftFromRt ? fields.rt[`SHAMT_WIDTH-1:0]
                                      : fields.imm[`SHAMT_WIDTH-1:0];
        isRight    = (ctrl.shiftOp == rotRight) || (ctrl.shiftOp == shiftRight);
        isRotate   = (ctrl.shiftOp == rotLeft) || (ctrl.shiftOp == rotRight);
        rsReversed = reverseBits(fields.rs);
        // right forms run the left barrel on flipped data
        barrelIn   = isRight ? rsReversed : fields.rs;
    end

    // one level per count bit
    always_comb begin
        barrelOut = barrelIn;
        for (int k = 0; k < `SHAMT_WIDTH; k++) begin
            if (amount[k]) begin
                if (isRotate) begin
                    barrelOut = (barrelOut << (1 << k)) | (barrelOut >> (`DATA_WIDTH - (1 << k)));
                end else begin
                    barrelOut = barrelOut << (1 << k);
                end
            end
        end
    end

    always_comb begin
        shift.shifted  = isRight ? reverseBits(barrelOut) : barrelOut;
        shift.reversed = rsReversed;
        shift.lbi      = {{(`DATA_WIDTH-`IMM_WIDTH){fields.imm[`IMM_WIDTH-1]}}, fields.imm};
        shift.slbi     = {fields.rs[`IMM_WIDTH-1:0], fields.imm};
    end

endmodule

`default_nettype wire
